// File: pcs_defines.svh
`ifndef PCS_DEFINES_SVH
`define PCS_DEFINES_SVH

// block and word widths
`define PCS_NB_DATA             64
`define PCS_NB_CTRL             8
`define PCS_NB_SH               2

// frame shape of the generator
`define PCS_FRAME_DATA_BLOCKS   8
`define PCS_IDLE_BLOCKS         4

// block lock thresholds
`define PCS_LOCK_VALID_SH       64
`define PCS_SH_WINDOW           64
`define PCS_SH_INVALID_LIMIT    16

// status counter widths
`define PCS_NB_COUNTER          16
`define PCS_NB_RESYNC           8

// start value of the x^58 + x^39 + 1 history on both ends
`define PCS_SCRAMBLER_SEED      58'h1A5_5A5A_5A5A_5A5A

`endif

// File: pcs_block_pkg.sv
`default_nettype none

`include "pcs_defines.svh"

package pcs_block_pkg;

    // 01 and 10 are the only legal headers
    typedef enum logic [`PCS_NB_SH-1:0]
    {
        SH_DATA = 2'b01,
        SH_CTRL = 2'b10
    } sync_header_e;

    // block type field in the first payload byte of a control block
    typedef enum logic [7:0]
    {
        BT_IDLE  = 8'h1E,
        BT_START = 8'h78,
        BT_TERM  = 8'h87
    } block_type_e;

    // xgmii control characters
    localparam logic [7:0] XGMII_IDLE     = 8'h07;
    localparam logic [7:0] XGMII_START    = 8'hFB;
    localparam logic [7:0] XGMII_TERM     = 8'hFD;
    localparam logic [7:0] XGMII_PREAMBLE = 8'h55;

    typedef struct packed
    {
        logic                    valid;
        logic [`PCS_NB_CTRL-1:0] ctrl;
        logic [`PCS_NB_DATA-1:0] data;
    } xgmii_word_t;

    // sh kept as plain bits so a broken header can travel
    typedef struct packed
    {
        logic                    valid;
        logic [`PCS_NB_SH-1:0]   sh;
        logic [`PCS_NB_DATA-1:0] payload;
    } coded_block_t;

endpackage

`default_nettype wire

// File: pcs_status_pkg.sv
`default_nettype none

`include "pcs_defines.svh"

package pcs_status_pkg;

    typedef enum logic [1:0]
    {
        SYNC_INIT,
        SYNC_TEST,
        SYNC_LOCKED
    } sync_state_e;

    typedef enum logic
    {
        DEC_IDLE,
        DEC_DATA
    } decode_state_e;

    typedef struct packed
    {
        logic                      block_lock;
        logic [`PCS_NB_RESYNC-1:0] resync_count;
    } sync_status_t;

    typedef struct packed
    {
        logic [`PCS_NB_COUNTER-1:0] frame_count;
        logic [`PCS_NB_COUNTER-1:0] error_count;
    } decode_status_t;

endpackage

`default_nettype wire

// File: pcs_frame_gen.sv
`default_nettype none

`include "pcs_defines.svh"

module pcs_frame_gen
(
    input  wire                        i_clock,
    input  wire                        i_reset,
    input  wire                        i_enable,
    output pcs_block_pkg::xgmii_word_t o_word
);

    localparam int FRAME_LEN = `PCS_FRAME_DATA_BLOCKS + `PCS_IDLE_BLOCKS + 2;
    localparam int NB_POS    = $clog2(FRAME_LEN);
    localparam int TERM_POS  = `PCS_FRAME_DATA_BLOCKS + 1;

    logic [NB_POS-1:0]          pos_q;
    logic [7:0]                 data_cnt_q;
    logic                       is_data;
    pcs_block_pkg::xgmii_word_t word_next;

    assign is_data = (pos_q != '0) && (pos_q < TERM_POS);

    always_comb
    begin
        word_next.valid = i_enable;
        word_next.ctrl  = '1;
        word_next.data  = {8{pcs_block_pkg::XGMII_IDLE}};
        if (pos_q == '0)
        begin
            word_next.ctrl = 8'h01;
            word_next.data = {{7{pcs_block_pkg::XGMII_PREAMBLE}}, pcs_block_pkg::XGMII_START};
        end
        else if (is_data)
        begin
            word_next.ctrl = '0;
            // byte k carries running count plus k
            for (int k = 0; k < `PCS_NB_CTRL; k++)
                word_next.data[8*k +: 8] = data_cnt_q + 8'(k);
        end
        else if (pos_q == TERM_POS)
        begin
            word_next.data = {{7{pcs_block_pkg::XGMII_IDLE}}, pcs_block_pkg::XGMII_TERM};
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            pos_q        <= '0;
            data_cnt_q   <= '0;
            o_word.valid <= 1'b0;
        end
        else
        begin
            o_word.valid <= word_next.valid;
            // position only moves on enabled cycles
            if (i_enable)
            begin
                pos_q <= (pos_q == FRAME_LEN - 1) ? '0 : pos_q + 1'b1;
                if (is_data)
                    data_cnt_q <= data_cnt_q + 8'd8;
            end
        end
        o_word.ctrl <= word_next.ctrl;
        o_word.data <= word_next.data;
    end

endmodule

`default_nettype wire

// File: pcs_encoder.sv
`default_nettype none

`include "pcs_defines.svh"

module pcs_encoder
(
    input  wire                         i_clock,
    input  wire                         i_reset,
    input  wire                         i_break_sync_header,
    input  wire pcs_block_pkg::xgmii_word_t i_word,
    output pcs_block_pkg::coded_block_t o_block
);

    logic [`PCS_NB_SH-1:0]   sh_next;
    logic [`PCS_NB_DATA-1:0] payload_next;

    always_comb
    begin
        sh_next      = pcs_block_pkg::SH_CTRL;
        payload_next = '0;
        if (i_word.ctrl == '0)
        begin
            sh_next      = pcs_block_pkg::SH_DATA;
            payload_next = i_word.data;
        end
        else if (i_word.ctrl == 8'h01 && i_word.data[7:0] == pcs_block_pkg::XGMII_START)
        begin
            payload_next = {i_word.data[`PCS_NB_DATA-1:8], pcs_block_pkg::BT_START};
        end
        else if (i_word.ctrl == '1 && i_word.data[7:0] == pcs_block_pkg::XGMII_TERM)
        begin
            payload_next = {56'h0, pcs_block_pkg::BT_TERM};
        end
        else if (i_word.ctrl == '1 && i_word.data == {8{pcs_block_pkg::XGMII_IDLE}})
        begin
            payload_next = {56'h0, pcs_block_pkg::BT_IDLE};
        end
        // anything else leaves type 00 for the decoder to flag
        if (i_break_sync_header)
            sh_next = 2'b00;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_block.valid <= 1'b0;
        else
            o_block.valid <= i_word.valid;
        o_block.sh      <= sh_next;
        o_block.payload <= payload_next;
    end

endmodule

`default_nettype wire

// File: pcs_scrambler.sv
`default_nettype none

`include "pcs_defines.svh"

module pcs_scrambler
(
    input  wire                         i_clock,
    input  wire                         i_reset,
    input  wire                         i_bypass,
    input  wire pcs_block_pkg::coded_block_t i_block,
    output pcs_block_pkg::coded_block_t o_block
);

    logic [57:0]             history_q;
    logic [57:0]             history_next;
    logic [`PCS_NB_DATA-1:0] scrambled;

    // bit 0 goes out first
    always_comb
    begin
        logic [57:0] s;
        logic        bit_out;
        s = history_q;
        for (int i = 0; i < `PCS_NB_DATA; i++)
        begin
            bit_out      = i_block.payload[i] ^ s[38] ^ s[57];
            scrambled[i] = bit_out;
            s            = {s[56:0], i_bypass ? i_block.payload[i] : bit_out};
        end
        history_next = s;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            history_q     <= `PCS_SCRAMBLER_SEED;
            o_block.valid <= 1'b0;
        end
        else
        begin
            o_block.valid <= i_block.valid;
            if (i_block.valid)
                history_q <= history_next;
        end
        o_block.sh      <= i_block.sh;
        o_block.payload <= i_bypass ? i_block.payload : scrambled;
    end

endmodule

`default_nettype wire

// File: pcs_block_sync.sv
`default_nettype none

`include "pcs_defines.svh"

module pcs_block_sync
(
    input  wire                          i_clock,
    input  wire                          i_reset,
    input  wire pcs_block_pkg::coded_block_t  i_block,
    output pcs_block_pkg::coded_block_t  o_block,
    output pcs_status_pkg::sync_status_t o_sync
);

    localparam int MAX_SH_CNT = (`PCS_LOCK_VALID_SH > `PCS_SH_WINDOW) ?
                                `PCS_LOCK_VALID_SH : `PCS_SH_WINDOW;
    localparam int NB_SH_CNT  = $clog2(MAX_SH_CNT + 1);
    localparam int NB_INV_CNT = $clog2(`PCS_SH_INVALID_LIMIT + 1);

    pcs_status_pkg::sync_state_e state_q;
    logic [NB_SH_CNT-1:0]        sh_cnt_q;
    logic [NB_INV_CNT-1:0]       inv_cnt_q;
    logic [NB_INV_CNT-1:0]       inv_cnt_next;
    logic [`PCS_NB_RESYNC-1:0]   resync_q;
    logic                        sh_valid;

    assign sh_valid     = (i_block.sh == pcs_block_pkg::SH_DATA) ||
                          (i_block.sh == pcs_block_pkg::SH_CTRL);
    assign inv_cnt_next = inv_cnt_q + NB_INV_CNT'(!sh_valid);

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            state_q   <= pcs_status_pkg::SYNC_INIT;
            sh_cnt_q  <= '0;
            inv_cnt_q <= '0;
            resync_q  <= '0;
        end
        else if (i_block.valid)
        begin
            case (state_q)
                pcs_status_pkg::SYNC_INIT:
                begin
                    state_q   <= pcs_status_pkg::SYNC_TEST;
                    sh_cnt_q  <= '0;
                    inv_cnt_q <= '0;
                end
                pcs_status_pkg::SYNC_TEST:
                begin
                    // bit aligned channel so a bad header just restarts the run
                    if (!sh_valid)
                        sh_cnt_q <= '0;
                    else if (sh_cnt_q == `PCS_LOCK_VALID_SH - 1)
                    begin
                        state_q  <= pcs_status_pkg::SYNC_LOCKED;
                        sh_cnt_q <= '0;
                    end
                    else
                        sh_cnt_q <= sh_cnt_q + 1'b1;
                end
                default:
                begin
                    if (inv_cnt_next == `PCS_SH_INVALID_LIMIT)
                    begin
                        state_q <= pcs_status_pkg::SYNC_INIT;
                        if (resync_q != '1)
                            resync_q <= resync_q + 1'b1;
                    end
                    else if (sh_cnt_q == `PCS_SH_WINDOW - 1)
                    begin
                        sh_cnt_q  <= '0;
                        inv_cnt_q <= '0;
                    end
                    else
                    begin
                        sh_cnt_q  <= sh_cnt_q + 1'b1;
                        inv_cnt_q <= inv_cnt_next;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_block.valid <= 1'b0;
        else
            o_block.valid <= i_block.valid && (state_q == pcs_status_pkg::SYNC_LOCKED);
        o_block.sh      <= i_block.sh;
        o_block.payload <= i_block.payload;
    end

    assign o_sync.block_lock   = (state_q == pcs_status_pkg::SYNC_LOCKED);
    assign o_sync.resync_count = resync_q;

endmodule

`default_nettype wire

// File: pcs_descrambler.sv
`default_nettype none

`include "pcs_defines.svh"

module pcs_descrambler
(
    input  wire                         i_clock,
    input  wire                         i_reset,
    input  wire                         i_bypass,
    input  wire pcs_block_pkg::coded_block_t i_block,
    output pcs_block_pkg::coded_block_t o_block
);

    logic [57:0]             history_q;
    logic [57:0]             history_next;
    logic [`PCS_NB_DATA-1:0] descrambled;

    // history takes the line bits, so it realigns after one block
    always_comb
    begin
        logic [57:0] s;
        s = history_q;
        for (int i = 0; i < `PCS_NB_DATA; i++)
        begin
            descrambled[i] = i_block.payload[i] ^ s[38] ^ s[57];
            s              = {s[56:0], i_block.payload[i]};
        end
        history_next = s;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            history_q     <= `PCS_SCRAMBLER_SEED;
            o_block.valid <= 1'b0;
        end
        else
        begin
            o_block.valid <= i_block.valid;
            if (i_block.valid)
                history_q <= history_next;
        end
        o_block.sh      <= i_block.sh;
        o_block.payload <= i_bypass ? i_block.payload : descrambled;
    end

endmodule

`default_nettype wire

// File: pcs_decoder.sv
`default_nettype none

`include "pcs_defines.svh"

module pcs_decoder
(
    input  wire                            i_clock,
    input  wire                            i_reset,
    input  wire pcs_block_pkg::coded_block_t    i_block,
    output pcs_status_pkg::decode_status_t o_status
);

    localparam int NB_DATA_CNT = $clog2(`PCS_FRAME_DATA_BLOCKS + 2);

    pcs_status_pkg::decode_state_e state_q;
    pcs_status_pkg::decode_state_e state_next;
    logic [NB_DATA_CNT-1:0]        data_cnt_q;
    logic [NB_DATA_CNT-1:0]        data_cnt_next;
    logic [`PCS_NB_COUNTER-1:0]    frame_cnt_q;
    logic [`PCS_NB_COUNTER-1:0]    error_cnt_q;
    logic                          is_error;
    logic                          is_frame;

    always_comb
    begin
        state_next    = state_q;
        data_cnt_next = data_cnt_q;
        is_error      = 1'b0;
        is_frame      = 1'b0;
        if (i_block.sh == pcs_block_pkg::SH_DATA)
        begin
            if (state_q == pcs_status_pkg::DEC_IDLE)
                is_error = 1'b1;
            else if (data_cnt_q != '1)
                data_cnt_next = data_cnt_q + 1'b1;
        end
        else if (i_block.sh == pcs_block_pkg::SH_CTRL)
        begin
            case (i_block.payload[7:0])
                pcs_block_pkg::BT_START:
                begin
                    is_error      = (state_q == pcs_status_pkg::DEC_DATA);
                    state_next    = pcs_status_pkg::DEC_DATA;
                    data_cnt_next = '0;
                end
                pcs_block_pkg::BT_TERM:
                begin
                    is_frame   = (state_q == pcs_status_pkg::DEC_DATA) &&
                                 (data_cnt_q == `PCS_FRAME_DATA_BLOCKS);
                    is_error   = !is_frame;
                    state_next = pcs_status_pkg::DEC_IDLE;
                end
                // idle inside a frame just abandons it
                pcs_block_pkg::BT_IDLE:
                    state_next = pcs_status_pkg::DEC_IDLE;
                default:
                begin
                    is_error   = 1'b1;
                    state_next = pcs_status_pkg::DEC_IDLE;
                end
            endcase
        end
        else
        begin
            is_error   = 1'b1;
            state_next = pcs_status_pkg::DEC_IDLE;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            state_q     <= pcs_status_pkg::DEC_IDLE;
            data_cnt_q  <= '0;
            frame_cnt_q <= '0;
            error_cnt_q <= '0;
        end
        else if (i_block.valid)
        begin
            state_q    <= state_next;
            data_cnt_q <= data_cnt_next;
            // both counters hold at full scale
            if (is_frame && frame_cnt_q != '1)
                frame_cnt_q <= frame_cnt_q + 1'b1;
            if (is_error && error_cnt_q != '1)
                error_cnt_q <= error_cnt_q + 1'b1;
        end
    end

    assign o_status.frame_count = frame_cnt_q;
    assign o_status.error_count = error_cnt_q;

endmodule

`default_nettype wire

// File: pcs_loopback_top.sv
`default_nettype none

module pcs_loopback_top
(
    input  wire                            i_clock,
    input  wire                            i_reset,
    input  wire                            i_tx_enable,
    input  wire                            i_scrambler_bypass,
    input  wire                            i_break_sync_header,
    output pcs_status_pkg::sync_status_t   o_sync,
    output pcs_status_pkg::decode_status_t o_decode
);

    pcs_block_pkg::xgmii_word_t  tx_word;
    pcs_block_pkg::coded_block_t tx_encoded;
    pcs_block_pkg::coded_block_t tx_scrambled;
    pcs_block_pkg::coded_block_t rx_locked;
    pcs_block_pkg::coded_block_t rx_descrambled;

    pcs_frame_gen u_frame_gen
    (
        .i_clock             (i_clock),
        .i_reset             (i_reset),
        .i_enable            (i_tx_enable),
        .o_word              (tx_word)
    );

    pcs_encoder u_encoder
    (
        .i_clock             (i_clock),
        .i_reset             (i_reset),
        .i_break_sync_header (i_break_sync_header),
        .i_word              (tx_word),
        .o_block             (tx_encoded)
    );

    pcs_scrambler u_scrambler
    (
        .i_clock             (i_clock),
        .i_reset             (i_reset),
        .i_bypass            (i_scrambler_bypass),
        .i_block             (tx_encoded),
        .o_block             (tx_scrambled)
    );

    // tx output loops straight into rx
    pcs_block_sync u_block_sync
    (
        .i_clock             (i_clock),
        .i_reset             (i_reset),
        .i_block             (tx_scrambled),
        .o_block             (rx_locked),
        .o_sync              (o_sync)
    );

    pcs_descrambler u_descrambler
    (
        .i_clock             (i_clock),
        .i_reset             (i_reset),
        .i_bypass            (i_scrambler_bypass),
        .i_block             (rx_locked),
        .o_block             (rx_descrambled)
    );

    pcs_decoder u_decoder
    (
        .i_clock             (i_clock),
        .i_reset             (i_reset),
        .i_block             (rx_descrambled),
        .o_status            (o_decode)
    );

endmodule

`default_nettype wire

// File: pcs_loopback_asserts.sv
`default_nettype none

module pcs_loopback_asserts
(
    input wire                                 i_clock,
    input wire                                 i_reset,
    input wire pcs_status_pkg::sync_status_t   i_sync,
    input wire pcs_status_pkg::decode_status_t i_decode
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    property error_count_no_decrease;
        @(posedge i_clock) disable iff (i_reset)
        !$past(i_reset) |-> i_decode.error_count >= $past(i_decode.error_count);
    endproperty

    // at most one terminate reaches the decoder per clock
    property frame_count_single_step;
        @(posedge i_clock) disable iff (i_reset)
        !$past(i_reset) |-> (i_decode.frame_count == $past(i_decode.frame_count)) ||
                            (i_decode.frame_count == $past(i_decode.frame_count) + 1'b1);
    endproperty

    property lock_low_after_reset;
        @(posedge i_clock) i_reset |=> !i_sync.block_lock;
    endproperty

    assert property (error_count_no_decrease)
        else
        begin
            fail_count++;
            $error("error_count decreased outside reset");
        end

    assert property (frame_count_single_step)
        else
        begin
            fail_count++;
            $error("frame_count moved by more than one in a cycle");
        end

    assert property (lock_low_after_reset)
        else
        begin
            fail_count++;
            $error("block_lock was high in the cycle after reset");
        end

endmodule

bind pcs_loopback_top pcs_loopback_asserts u_asserts
(
    .i_clock  (i_clock),
    .i_reset  (i_reset),
    .i_sync   (o_sync),
    .i_decode (o_decode)
);

`default_nettype wire

// File: tb_pcs_loopback.sv
`default_nettype none

`include "pcs_defines.svh"

module tb_pcs_loopback;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_LEN    = `PCS_FRAME_DATA_BLOCKS + `PCS_IDLE_BLOCKS + 2;
    localparam int LOCK_TIMEOUT = 200;
    localparam int DRAIN_CYCLES = 10;

    logic                           i_clock;
    logic                           i_reset;
    logic                           i_tx_enable;
    logic                           i_scrambler_bypass;
    logic                           i_break_sync_header;
    pcs_status_pkg::sync_status_t   o_sync;
    pcs_status_pkg::decode_status_t o_decode;

    int mismatch_count;
    int failure_count;

    pcs_loopback_top i_dut
    (
        .i_clock             (i_clock),
        .i_reset             (i_reset),
        .i_tx_enable         (i_tx_enable),
        .i_scrambler_bypass  (i_scrambler_bypass),
        .i_break_sync_header (i_break_sync_header),
        .o_sync              (o_sync),
        .o_decode            (o_decode)
    );

    always #20 i_clock = ~i_clock;

    task automatic report_mismatch(input string name, input int actual, input string expected);
        $display("MISMATCH at %0t: %s is %0d, expected %s", $time, name, actual, expected);
        mismatch_count++;
    endtask

    // outputs are read at the falling edge
    task automatic run_cycles(input int n);
        repeat (n) @(posedge i_clock);
        @(negedge i_clock);
    endtask

    task automatic wait_lock(input logic level, input int limit);
        int n;
        n = 0;
        while (o_sync.block_lock !== level && n < limit)
        begin
            @(negedge i_clock);
            n++;
        end
        if (o_sync.block_lock !== level)
        begin
            $display("timeout: block_lock did not reach %0b within %0d cycles", level, limit);
            failure_count++;
        end
    endtask

    task automatic apply_reset(input logic bypass);
        @(posedge i_clock);
        i_reset             <= 1'b1;
        i_tx_enable         <= 1'b0;
        i_break_sync_header <= 1'b0;
        i_scrambler_bypass  <= bypass;
        repeat (16) @(posedge i_clock);
        i_reset <= 1'b0;
        @(negedge i_clock);
    endtask

    task automatic check_reset_state();
        if (o_sync.block_lock !== 1'b0)
            report_mismatch("o_sync.block_lock", int'(o_sync.block_lock), "0");
        if (o_sync.resync_count !== '0)
            report_mismatch("o_sync.resync_count", int'(o_sync.resync_count), "0");
        if (o_decode.frame_count !== '0)
            report_mismatch("o_decode.frame_count", int'(o_decode.frame_count), "0");
        if (o_decode.error_count !== '0)
            report_mismatch("o_decode.error_count", int'(o_decode.error_count), "0");
    endtask

    task automatic check_lock_gain();
        @(posedge i_clock);
        i_tx_enable <= 1'b1;
        wait_lock(1'b1, LOCK_TIMEOUT);
    endtask

    task automatic check_long_run(input int n_frames);
        int frames_before;
        int errors_before;
        int frame_delta;
        // decoder may start mid frame after lock
        run_cycles(3 * FRAME_LEN);
        frames_before = int'(o_decode.frame_count);
        errors_before = int'(o_decode.error_count);
        run_cycles(n_frames * FRAME_LEN);
        frame_delta = int'(o_decode.frame_count) - frames_before;
        if (frame_delta < n_frames - 1)
            report_mismatch("frame_count delta", frame_delta, $sformatf(">= %0d", n_frames - 1));
        if (frame_delta > n_frames + 1)
            report_mismatch("frame_count delta", frame_delta, $sformatf("<= %0d", n_frames + 1));
        if (int'(o_decode.error_count) != errors_before)
            report_mismatch("o_decode.error_count", int'(o_decode.error_count),
                            $sformatf("%0d", errors_before));
    endtask

    task automatic check_sync_break();
        int   resync_before;
        int   errors_before;
        logic lock_lost;
        resync_before = int'(o_sync.resync_count);
        errors_before = int'(o_decode.error_count);
        lock_lost     = 1'b0;
        @(posedge i_clock);
        i_break_sync_header <= 1'b1;
        // 40 broken headers reach the encoder
        for (int i = 0; i < 40; i++)
        begin
            @(negedge i_clock);
            if (!o_sync.block_lock)
                lock_lost = 1'b1;
        end
        @(posedge i_clock);
        i_break_sync_header <= 1'b0;
        if (!lock_lost)
        begin
            $display("block_lock never dropped while sync headers were broken");
            failure_count++;
        end
        wait_lock(1'b1, LOCK_TIMEOUT);
        if (int'(o_sync.resync_count) != resync_before + 1)
            report_mismatch("o_sync.resync_count", int'(o_sync.resync_count),
                            $sformatf("%0d", resync_before + 1));
        if (int'(o_decode.error_count) <= errors_before)
            report_mismatch("o_decode.error_count", int'(o_decode.error_count),
                            $sformatf("> %0d", errors_before));
    endtask

    task automatic check_enable_gaps();
        int frames_start;
        int errors_start;
        int frames_held;
        int enabled_cycles;
        int burst;
        int gap;
        run_cycles(3 * FRAME_LEN);
        frames_start   = int'(o_decode.frame_count);
        errors_start   = int'(o_decode.error_count);
        enabled_cycles = 0;
        for (int k = 0; k < 4; k++)
        begin
            burst = 20 + int'($urandom % 41);
            gap   = 10 + int'($urandom % 91);
            @(posedge i_clock);
            i_tx_enable <= 1'b1;
            run_cycles(burst);
            @(posedge i_clock);
            i_tx_enable <= 1'b0;
            enabled_cycles += burst + 1;
            run_cycles(DRAIN_CYCLES);
            frames_held = int'(o_decode.frame_count);
            run_cycles(gap);
            if (int'(o_decode.frame_count) != frames_held)
                report_mismatch("o_decode.frame_count", int'(o_decode.frame_count),
                                $sformatf("%0d", frames_held));
        end
        if (int'(o_decode.frame_count) - frames_start < enabled_cycles / FRAME_LEN - 1)
            report_mismatch("frame_count delta", int'(o_decode.frame_count) - frames_start,
                            $sformatf(">= %0d", enabled_cycles / FRAME_LEN - 1));
        if (int'(o_decode.error_count) != errors_start)
            report_mismatch("o_decode.error_count", int'(o_decode.error_count),
                            $sformatf("%0d", errors_start));
        @(posedge i_clock);
        i_tx_enable <= 1'b1;
    endtask

    initial
    begin
        i_clock             = 1'b0;
        i_reset             = 1'b1;
        i_tx_enable         = 1'b0;
        i_scrambler_bypass  = 1'b0;
        i_break_sync_header = 1'b0;
        mismatch_count      = 0;
        failure_count       = 0;
        void'($urandom(31846));

        apply_reset(1'b0);
        check_reset_state();
        check_lock_gain();
        check_long_run(100);
        check_sync_break();
        check_enable_gaps();

        // same run again with both scramblers bypassed
        apply_reset(1'b1);
        check_reset_state();
        check_lock_gain();
        check_long_run(100);

        $display("mismatches: %0d, other errors: %0d, assertion failures: %0d",
                 mismatch_count, failure_count, i_dut.u_asserts.fail_count);
        if (mismatch_count + failure_count + i_dut.u_asserts.fail_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
pcs_block_pkg.sv
pcs_status_pkg.sv
pcs_frame_gen.sv
pcs_encoder.sv
pcs_scrambler.sv
pcs_block_sync.sv
pcs_descrambler.sv
pcs_decoder.sv
pcs_loopback_top.sv
pcs_loopback_asserts.sv
tb_pcs_loopback.sv

// File: run_sim.sh
#!/bin/sh
# build and run the 64b/66b loopback testbench with verilator

LOG=sim.log

verilator --binary --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_pcs_loopback -f sim.f -o tb_pcs_loopback
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_pcs_loopback > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    exit 1
fi
exit 0
